//--- Bender.yml
package:
  name: uart_echo

dependencies: {}

sources:
  - logic/uart_pkg.sv
  - logic/uart_rx.sv
  - logic/uart_fifo.sv
  - logic/uart_tx.sv
  - logic/uart_echo_top.sv

  - target: test
    files:
      - dv/uart_echo_tb.sv

//--- flist.f
logic/uart_pkg.sv
logic/uart_rx.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_echo_top.sv
dv/uart_echo_tb.sv

//--- dv/uart_echo_tb.sv
/*
 * UART echo bridge testbench
 * Drives serial frames into the DUT and checks the echoed frames and status
 */
`timescale 1ns/100ps

module uart_echo_tb;

    import uart_pkg::*;

    localparam int CLK_FREQ    = 125_000_000;
    localparam int BAUD_RATE   = 7_812_500;
    localparam int W           = 8;
    localparam int FIFO_DEPTH  = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int R           = CLK_FREQ / BAUD_RATE;     // 16 cycles per bit
    localparam int FRAME_COUNT = 39;                        // Frames sent plus frames echoed
    localparam int WATCHDOG_NS = (FRAME_COUNT * (10 * R + 20) + 2000) * CLK_PERIOD;

    logic         clk;
    logic         arstn;
    logic         uart_rx;
    logic         uart_cts_n;
    logic         uart_tx;
    uart_status_t status;

    logic [W-1:0] exp_q[$];                     // Bytes still due on uart_tx_o
    integer       seed = 32'h5f4e;
    int           value_errors  = 0;
    int           other_errors  = 0;
    int           frame_err_cnt = 0;
    int           overflow_cnt  = 0;

    uart_echo_top #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .DATA_WIDTH (W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk_i        (clk),
        .arstn_i      (arstn),
        .uart_rx_i    (uart_rx),
        .uart_cts_n_i (uart_cts_n),
        .uart_tx_o    (uart_tx),
        .status_o     (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // #########################################################################
    // Compare tasks

    task automatic check_byte(input string name, input uart_beat_t exp, input uart_beat_t act);
        if (act.data !== exp.data) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected 0x%02h, got 0x%02h",
                     $time, name, exp.data, act.data);
        end
    endtask

    task automatic check_status(input string name, input uart_status_t exp,
                                input uart_status_t act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    function automatic uart_status_t status_of(input logic fe, input logic ov, input int lvl);
        uart_status_t s;
        s.frame_err = fe;
        s.overflow  = ov;
        s.level     = lvl[7:0];
        return s;
    endfunction

    // #########################################################################
    // Serial driver and monitor

    // Start bit, data LSB first, then a high or a low stop bit
    task automatic send_frame(input logic [W-1:0] data, input logic good_stop);
        logic [W+1:0] bits;
        int           i;
        bits = {good_stop, data, 1'b0};
        for (i = 0; i < W + 2; i++) begin
            @(posedge clk);
            uart_rx <= bits[i];
            repeat (R - 1) @(posedge clk);
        end
        if (!good_stop) begin
            @(posedge clk);
            uart_rx <= 1'b1;    // Back to idle for one bit time
            repeat (R - 1) @(posedge clk);
        end
    endtask

    task automatic receive_frame(output logic start_bit, output logic [W-1:0] data,
                                 output logic stop_bit);
        int i;
        @(negedge uart_tx);
        repeat (R / 2) @(negedge clk);  // Middle of the start bit
        start_bit = uart_tx;
        for (i = 0; i < W; i++) begin
            repeat (R) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (R) @(negedge clk);
        stop_bit = uart_tx;
    endtask

    initial begin : frame_monitor
        logic         start_bit;
        logic         stop_bit;
        logic [W-1:0] data;
        uart_beat_t   exp_beat;
        uart_beat_t   act_beat;
        wait (arstn === 1'b1);
        forever begin
            receive_frame(start_bit, data, stop_bit);
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Unexpected frame on uart_tx_o at %0t carrying 0x%02h", $time, data);
            end else begin
                exp_beat                = '0;
                exp_beat.data[W-1:0]    = exp_q.pop_front();
                act_beat                = '0;
                act_beat.data[W-1:0]    = data;
                check_byte("uart_tx_o data", exp_beat, act_beat);
                check_bit("uart_tx_o start bit", 1'b0, start_bit);
                check_bit("uart_tx_o stop bit", 1'b1, stop_bit);
            end
        end
    end

    // Pulse counters and level bound
    always @(negedge clk) begin
        if (arstn === 1'b1) begin
            if (status.frame_err) frame_err_cnt++;
            if (status.overflow)  overflow_cnt++;
            if (status.level > FIFO_DEPTH) begin
                other_errors++;
                $display("FIFO level reached %0d at %0t, above the depth of %0d",
                         status.level, $time, FIFO_DEPTH);
            end
        end
    end

    // Waits until every expected byte has been echoed, then lets the frame end
    task automatic wait_drain();
        int cycles;
        int limit;
        cycles = 0;
        limit  = (exp_q.size() + 1) * (10 * R + 20);
        while ((exp_q.size() != 0) && (cycles < limit)) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Echo timeout at %0t: %0d expected bytes never appeared on uart_tx_o",
                     $time, exp_q.size());
            exp_q.delete();
        end
        repeat (R) @(posedge clk);
    endtask

    // #########################################################################
    // Directed tests

    task automatic verify_reset();
        @(negedge clk);
        check_bit("uart_tx_o", 1'b1, uart_tx);
        check_status("status_o", status_of(1'b0, 1'b0, 0), status);
    endtask

    task automatic single_echo();
        exp_q.push_back(8'ha5);
        send_frame(8'ha5, 1'b1);
        wait_drain();
    endtask

    task automatic ordered_stream();
        int           fe0;
        int           ov0;
        int           i;
        logic [31:0]  rnd;
        fe0 = frame_err_cnt;
        ov0 = overflow_cnt;
        for (i = 0; i < 12; i++) begin
            rnd = $random(seed);
            exp_q.push_back(rnd[W-1:0]);
            send_frame(rnd[W-1:0], 1'b1);
        end
        wait_drain();
        check_count("frame_err pulses", fe0, frame_err_cnt);
        check_count("overflow pulses", ov0, overflow_cnt);
    endtask

    task automatic framing_error();
        int          fe0;
        int          ov0;
        logic [31:0] rnd;
        fe0 = frame_err_cnt;
        ov0 = overflow_cnt;
        rnd = $random(seed);
        send_frame(rnd[W-1:0], 1'b0);   // Dropped, never echoed
        repeat (4) @(posedge clk);
        check_count("frame_err pulses", fe0 + 1, frame_err_cnt);
        @(negedge clk);
        check_status("status_o", status_of(1'b0, 1'b0, 0), status);
        exp_q.push_back(8'h3c);
        send_frame(8'h3c, 1'b1);
        wait_drain();
        check_count("frame_err pulses", fe0 + 1, frame_err_cnt);
        check_count("overflow pulses", ov0, overflow_cnt);
    endtask

    task automatic flow_control_overflow();
        logic [W-1:0] sent[6];
        logic [31:0]  rnd;
        int           ov0;
        int           i;
        ov0 = overflow_cnt;
        @(posedge clk);
        uart_cts_n <= 1'b1;
        for (i = 0; i < 6; i++) begin
            rnd     = $random(seed);
            sent[i] = rnd[W-1:0];
            send_frame(sent[i], 1'b1);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("uart_tx_o", 1'b1, uart_tx);
        check_status("status_o", status_of(1'b0, 1'b0, FIFO_DEPTH), status);
        check_count("overflow pulses", ov0 + 2, overflow_cnt);
        for (i = 0; i < FIFO_DEPTH; i++) begin
            exp_q.push_back(sent[i]);   // Last two bytes were lost
        end
        @(posedge clk);
        uart_cts_n <= 1'b0;
        wait_drain();
        @(negedge clk);
        check_status("status_o", status_of(1'b0, 1'b0, 0), status);
    endtask

    // #########################################################################
    // Sequence and watchdog

    initial begin
        arstn      = 1'b0;
        uart_rx    = 1'b1;
        uart_cts_n = 1'b0;
        repeat (16) @(posedge clk);
        arstn <= 1'b1;
        verify_reset();
        single_echo();
        ordered_stream();
        framing_error();
        flow_control_overflow();
        repeat (12 * R) @(posedge clk);   // Room for any stray frame to show up
        $display("Error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("Watchdog timeout at %0t: the tests did not finish in time", $time);
        $display("Error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- logic/uart_echo_top.sv
/*
 * UART echo bridge
 * Receiver into a FWFT FIFO into a flow-controlled transmitter
 */
`timescale 1ns/100ps

module uart_echo_top #(
    parameter int CLK_FREQ   = 125_000_000,
    parameter int BAUD_RATE  = 115_200,
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   arstn_i,
    input  logic                   uart_rx_i,
    input  logic                   uart_cts_n_i,
    output logic                   uart_tx_o,
    output uart_pkg::uart_status_t status_o
);

    import uart_pkg::*;

    uart_beat_t rx_beat;
    uart_beat_t tx_beat;
    logic       rx_ready;
    logic       tx_ready;
    logic       frame_err;
    logic       overflow;
    logic [7:0] level;

    uart_rx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_rx (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .uart_rx_i   (uart_rx_i),
        .beat_o      (rx_beat),
        .ready_i     (rx_ready),
        .frame_err_o (frame_err),
        .overflow_o  (overflow)
    );

    uart_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .wr_beat_i  (rx_beat),
        .wr_ready_o (rx_ready),
        .rd_beat_o  (tx_beat),
        .rd_ready_i (tx_ready),
        .level_o    (level)
    );

    uart_tx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_tx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .beat_i    (tx_beat),
        .ready_o   (tx_ready),
        .cts_n_i   (uart_cts_n_i),
        .uart_tx_o (uart_tx_o)
    );

    // Status word
    assign status_o.frame_err = frame_err;
    assign status_o.overflow  = overflow;
    assign status_o.level     = level;

endmodule

//--- logic/uart_tx.sv
/*
 * UART transmitter
 * Sends start, data LSB first and stop, then one wait cycle before the next beat
 */
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLK_FREQ   = 125_000_000,
    parameter int BAUD_RATE  = 115_200,
    parameter int DATA_WIDTH = 8
) (
    input  logic                 clk_i,
    input  logic                 arstn_i,
    input  uart_pkg::uart_beat_t beat_i,
    output logic                 ready_o,
    input  logic                 cts_n_i,
    output logic                 uart_tx_o
);

    import uart_pkg::*;

    localparam int RATIO = baud_ratio(CLK_FREQ, BAUD_RATE);
    localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;
    localparam int BIT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(RATIO - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(DATA_WIDTH - 1);

    uart_tx_state_e        state;
    logic [CNT_W-1:0]      baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  baud_done;
    logic                  bit_done;
    logic                  xfer;

    assign ready_o   = (state == TX_IDLE) && !cts_n_i;   // Clear-to-send gates new frames only
    assign xfer      = beat_i.valid & ready_o;
    assign baud_done = (baud_cnt == BAUD_LAST);
    assign bit_done  = (bit_cnt == BIT_LAST);

    // #########################################################################
    // Frame FSM, line is registered one state ahead

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state     <= TX_IDLE;
            uart_tx_o <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (xfer) begin
                        state     <= TX_START;
                        uart_tx_o <= 1'b0;  // Start bit
                    end
                end
                TX_START: begin
                    if (baud_done) begin
                        state     <= TX_DATA;
                        uart_tx_o <= tx_data[0];
                    end
                end
                TX_DATA: begin
                    if (baud_done) begin
                        if (bit_done) begin
                            state     <= TX_STOP;
                            uart_tx_o <= 1'b1;
                        end else begin
                            uart_tx_o <= tx_data[bit_cnt + 1'b1];
                        end
                    end
                end
                TX_STOP: begin
                    if (baud_done) begin
                        state <= TX_WAIT;
                    end
                end
                TX_WAIT: begin
                    state <= TX_IDLE;
                end
                default: begin
                    state     <= TX_IDLE;
                    uart_tx_o <= 1'b1;
                end
            endcase
        end
    end

    // #########################################################################
    // Baud and bit counters

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if (baud_done) begin
            baud_cnt <= '0;
        end else if ((state == TX_START) || (state == TX_DATA) || (state == TX_STOP)) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if ((state == TX_DATA) && baud_done) begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer) begin
            tx_data <= beat_i.data[DATA_WIDTH-1:0];
        end
    end

endmodule

//--- logic/uart_fifo.sv
/*
 * First-word-fall-through byte FIFO
 * Ring buffer with extended pointers, head entry always on the output
 */
`timescale 1ns/100ps

module uart_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 arstn_i,
    input  uart_pkg::uart_beat_t wr_beat_i,
    output logic                 wr_ready_o,
    output uart_pkg::uart_beat_t rd_beat_o,
    input  logic                 rd_ready_i,
    output logic [7:0]           level_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [AW:0]           wr_ptr;
    logic [AW:0]           rd_ptr;
    logic [AW:0]           fill;
    logic                  full;
    logic                  empty;
    logic                  wr_en;
    logic                  rd_en;

    // Same address, wrap bits differ when full
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready_o = ~full;
    assign wr_en      = wr_beat_i.valid & ~full;
    assign rd_en      = rd_beat_o.valid & rd_ready_i;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_beat_i.data[DATA_WIDTH-1:0];
        end
    end

    // Head of queue falls through
    always_comb begin
        rd_beat_o                      = '0;
        rd_beat_o.valid                = ~empty;
        rd_beat_o.data[DATA_WIDTH-1:0] = mem[rd_ptr[AW-1:0]];
    end

    assign fill    = wr_ptr - rd_ptr;   // Wraps with the pointers
    assign level_o = 8'(fill);

endmodule

//--- logic/uart_rx.sv
/*
 * UART receiver
 * Synchronizes the serial line, validates the start bit at its middle,
 * samples data LSB first and checks the stop bit
 */
`timescale 1ns/100ps

module uart_rx #(
    parameter int CLK_FREQ   = 125_000_000,
    parameter int BAUD_RATE  = 115_200,
    parameter int DATA_WIDTH = 8
) (
    input  logic                clk_i,
    input  logic                arstn_i,
    input  logic                uart_rx_i,
    output uart_pkg::uart_beat_t beat_o,
    input  logic                ready_i,
    output logic                frame_err_o,
    output logic                overflow_o
);

    import uart_pkg::*;

    localparam int RATIO = baud_ratio(CLK_FREQ, BAUD_RATE);
    localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;
    localparam int BIT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(RATIO - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(RATIO / 2 - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(DATA_WIDTH - 1);

    uart_rx_state_e        state;
    logic [1:0]            rx_sync;
    logic                  rx_line;
    logic                  rx_prev;
    logic                  start_edge;
    logic [CNT_W-1:0]      baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  sample_tick;
    logic                  bit_done;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  valid_q;
    logic                  frame_err_q;

    // #########################################################################
    // Input synchronizer and start edge

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_sync <= 2'b11;   // Line idles high
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
            rx_prev <= rx_line;
        end
    end

    assign rx_line    = rx_sync[1];
    assign start_edge = rx_prev & ~rx_line;

    // #########################################################################
    // Bit timing

    // Half a bit to the start bit middle, full bits after that
    assign sample_tick = (state == RX_START) ? (baud_cnt == HALF_LAST)
                                             : (baud_cnt == BAUD_LAST);
    assign bit_done    = (bit_cnt == BIT_LAST);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state == RX_IDLE) || sample_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if ((state == RX_DATA) && sample_tick) begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
        end
    end

    // #########################################################################
    // Frame FSM

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state       <= RX_IDLE;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample_tick) begin
                        state <= rx_line ? RX_IDLE : RX_DATA;   // Glitch if high again
                    end
                end
                RX_DATA: begin
                    if (sample_tick && bit_done) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (sample_tick) begin
                        state       <= RX_IDLE;
                        valid_q     <= rx_line;
                        frame_err_q <= ~rx_line;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_i) begin
        if ((state == RX_DATA) && sample_tick) begin
            shreg <= {rx_line, shreg[DATA_WIDTH-1:1]};
        end
    end

    always_comb begin
        beat_o                      = '0;
        beat_o.valid                = valid_q;
        beat_o.data[DATA_WIDTH-1:0] = shreg;
    end

    assign frame_err_o = frame_err_q;
    assign overflow_o  = valid_q & ~ready_i;    // Serial line cannot stall

endmodule

//--- logic/uart_pkg.sv
/*
 * UART echo bridge shared types
 * FSM state encodings, the valid/data beat, the status word and the baud helper
 */
package uart_pkg;

    localparam int UART_MAX_WIDTH = 8;  // Widest character the beat can carry

    typedef enum logic [2:0] {
        RX_IDLE  = 3'b000,
        RX_START = 3'b001,
        RX_DATA  = 3'b010,
        RX_STOP  = 3'b011
    } uart_rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE  = 3'b000,
        TX_START = 3'b001,
        TX_DATA  = 3'b010,
        TX_STOP  = 3'b011,
        TX_WAIT  = 3'b100
    } uart_tx_state_e;

    // Character sits in the low DATA_WIDTH bits of data
    typedef struct packed {
        logic                      valid;
        logic [UART_MAX_WIDTH-1:0] data;
    } uart_beat_t;

    typedef struct packed {
        logic       frame_err;  // One-cycle pulse, bad stop bit
        logic       overflow;   // One-cycle pulse, byte lost to a full FIFO
        logic [7:0] level;      // FIFO fill count
    } uart_status_t;

    // Clock cycles per serial bit
    function automatic int baud_ratio(input int clk_freq, input int baud_rate);
        return clk_freq / baud_rate;
    endfunction

endpackage
